/* logic/fetch_pkg.sv */
// Pipeline-side types of the fetch stage, imported by the RTL and the decode-side testbench
package fetch_pkg;

  ////////////////////////////////////////////////////////////
  // Privilege level and redirect source
  ////////////////////////////////////////////////////////////

  // Same encoding as the MPP field of mstatus
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } priv_lvl_e;

  // Where the next fetch address comes from on a redirect
  typedef enum logic [1:0] {
    PC_BOOT = 2'b00,
    PC_JUMP = 2'b01,
    PC_TRAP = 2'b10
  } pc_mux_e;

  ////////////////////////////////////////////////////////////
  // Controller command and IF/ID payload
  ////////////////////////////////////////////////////////////

  // Driven by the core controller every cycle
  typedef struct packed {
    logic        halt;
    logic        kill;
    logic        pc_set;
    pc_mux_e     pc_mux;
    // Only looked at for PC_JUMP
    logic [31:0] jump_target;
    // Takes effect together with pc_set
    priv_lvl_e   new_priv;
    logic        dummy_en;
  } fetch_cmd_t;

  // One instruction word handed to decode
  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] pc;
    priv_lvl_e   priv_lvl;
    logic        dummy;
    logic        bus_err;
  } if_id_t;

  // Dummy instruction, add x0, x0, x0
  localparam logic [31:0] DUMMY_INSTR = 32'h0000_0033;

endpackage

/* logic/ibus_pkg.sv */
// Instruction bus request and response types, shared by the prefetch buffer and the bus model
package ibus_pkg;

  ////////////////////////////////////////////////////////////
  // Request channel
  ////////////////////////////////////////////////////////////

  // Handshaked with valid/ready outside the struct
  typedef struct packed {
    // Always word aligned, bits [1:0] are zero
    logic [31:0] addr;
  } ibus_req_t;

  ////////////////////////////////////////////////////////////
  // Response channel
  ////////////////////////////////////////////////////////////

  // No back-pressure, responses come back in request order
  typedef struct packed {
    logic [31:0] rdata;
    // Access fault for this word
    logic        err;
  } ibus_rsp_t;

endpackage

/* logic/fetch_ctrl.sv */
// Fetch controller: sequences fetch address, privilege and flushes for the prefetch buffer
module fetch_ctrl
  import fetch_pkg::*;
#(
  parameter logic [31:0] BOOT_ADDR = 32'h0000_0080
) (
  input  logic        clk,
  input  logic        rst_n,
  input  fetch_cmd_t  fetch_cmd_i,
  input  logic [31:0] mtvec_i,
  input  logic        req_fire_i,
  input  logic        outstanding_zero_i,
  output logic [31:0] fetch_addr_o,
  output logic        fetch_en_o,
  output logic        flush_o,
  output priv_lvl_e   priv_lvl_o,
  output logic        halt_o,
  output logic        kill_o,
  output logic        dummy_en_o
);

  // RESET_WAIT spends one cycle before the first request
  // DRAIN parks fetching after a kill that carries no new target
  typedef enum logic [1:0] {
    RESET_WAIT,
    FETCH,
    DRAIN
  } fetch_state_e;

  fetch_state_e state_q;
  fetch_state_e state_d;
  logic [31:0]  fetch_addr_q;
  logic [31:0]  redirect_addr;
  priv_lvl_e    priv_q;
  logic         redirect;

  ////////////////////////////////////////////////////////////
  // Redirect target
  ////////////////////////////////////////////////////////////

  assign redirect = fetch_cmd_i.pc_set;

  always_comb begin
    case (fetch_cmd_i.pc_mux)
      PC_JUMP: redirect_addr = fetch_cmd_i.jump_target;
      // Mode bits of mtvec fall away with the word alignment below
      PC_TRAP: redirect_addr = mtvec_i;
      default: redirect_addr = BOOT_ADDR;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // State machine
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      RESET_WAIT: begin
        // Bus must be quiet before the boot fetch
        if (redirect || outstanding_zero_i)
          state_d = FETCH;
      end
      FETCH: begin
        // Kill alone leaves no valid address to continue from
        if (fetch_cmd_i.kill && !redirect)
          state_d = DRAIN;
      end
      DRAIN: begin
        if (redirect)
          state_d = FETCH;
      end
      default: state_d = RESET_WAIT;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= RESET_WAIT;
      fetch_addr_q <= {BOOT_ADDR[31:2], 2'b00};
      priv_q       <= PRIV_M;
    end else begin
      state_q <= state_d;
      // Redirect wins over the sequential increment
      if (redirect) begin
        fetch_addr_q <= {redirect_addr[31:2], 2'b00};
        priv_q       <= fetch_cmd_i.new_priv;
      end else if (req_fire_i) begin
        fetch_addr_q <= fetch_addr_q + 32'd4;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////

  // A redirect always discards the old sequential stream
  assign flush_o      = fetch_cmd_i.kill || redirect;
  // No request in a flush cycle, the new address is used one cycle later
  assign fetch_en_o   = (state_q == FETCH) && !flush_o;
  assign fetch_addr_o = fetch_addr_q;
  assign priv_lvl_o   = priv_q;
  assign halt_o       = fetch_cmd_i.halt;
  assign kill_o       = flush_o;
  assign dummy_en_o   = fetch_cmd_i.dummy_en;

endmodule

/* logic/prefetch_buffer.sv */
// Prefetch buffer: issues bus requests, tags returned words and queues them for the inserter
module prefetch_buffer
  import fetch_pkg::*;
  import ibus_pkg::*;
#(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [31:0] fetch_addr_i,
  input  logic        fetch_en_i,
  input  logic        flush_i,
  input  priv_lvl_e   priv_lvl_i,
  output logic        req_fire_o,
  output logic        outstanding_zero_o,
  output ibus_req_t   ibus_req_o,
  output logic        ibus_req_valid_o,
  input  logic        ibus_req_ready_i,
  input  ibus_rsp_t   ibus_rsp_i,
  input  logic        ibus_rsp_valid_i,
  output if_id_t      buf_o,
  output logic        buf_valid_o,
  input  logic        buf_ready_i
);

  localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam int unsigned SUM_W = CNT_W + 2;
  localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(FIFO_DEPTH - 1);

  // Slot allocated at request time, tag written then, data at response time
  logic [31:0]      tag_pc_q   [FIFO_DEPTH];
  priv_lvl_e        tag_priv_q [FIFO_DEPTH];
  ibus_rsp_t        data_q     [FIFO_DEPTH];

  logic [PTR_W-1:0] alloc_ptr_q;
  logic [PTR_W-1:0] fill_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  // Requests in flight for the current stream
  logic [CNT_W-1:0] live_cnt_q;
  // Words filled and waiting for the inserter
  logic [CNT_W-1:0] stored_cnt_q;
  // Requests in flight from before the last flush
  logic [CNT_W-1:0] stale_cnt_q;
  logic [SUM_W-1:0] inflight;
  logic             fill;
  logic             drop;
  logic             pop;

  // Wrap for depths that are not a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == LAST_SLOT) ? '0 : ptr + 1'b1;
  endfunction

  ////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////

  // Stale requests count too, so the bus never sees more than FIFO_DEPTH
  assign inflight = SUM_W'(stored_cnt_q) + SUM_W'(live_cnt_q) + SUM_W'(stale_cnt_q);

  assign ibus_req_valid_o   = fetch_en_i && (inflight < SUM_W'(FIFO_DEPTH));
  assign req_fire_o         = ibus_req_valid_o && ibus_req_ready_i;
  assign ibus_req_o.addr    = {fetch_addr_i[31:2], 2'b00};
  assign outstanding_zero_o = (live_cnt_q == '0) && (stale_cnt_q == '0);

  ////////////////////////////////////////////////////////////
  // Response side and pop
  ////////////////////////////////////////////////////////////

  // In-order return, so stale responses always come first
  assign drop = ibus_rsp_valid_i && (stale_cnt_q != '0);
  assign fill = ibus_rsp_valid_i && (stale_cnt_q == '0) && !flush_i;
  assign pop  = buf_ready_i && buf_valid_o && !flush_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      alloc_ptr_q  <= '0;
      fill_ptr_q   <= '0;
      rd_ptr_q     <= '0;
      live_cnt_q   <= '0;
      stored_cnt_q <= '0;
      stale_cnt_q  <= '0;
    end else if (flush_i) begin
      alloc_ptr_q  <= '0;
      fill_ptr_q   <= '0;
      rd_ptr_q     <= '0;
      live_cnt_q   <= '0;
      stored_cnt_q <= '0;
      // Live requests turn stale, minus whatever answers this cycle
      stale_cnt_q  <= stale_cnt_q + live_cnt_q - CNT_W'(ibus_rsp_valid_i);
    end else begin
      if (req_fire_o)
        alloc_ptr_q <= ptr_inc(alloc_ptr_q);
      if (fill)
        fill_ptr_q <= ptr_inc(fill_ptr_q);
      if (pop)
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      live_cnt_q   <= live_cnt_q + CNT_W'(req_fire_o) - CNT_W'(fill);
      stored_cnt_q <= stored_cnt_q + CNT_W'(fill) - CNT_W'(pop);
      stale_cnt_q  <= stale_cnt_q - CNT_W'(drop);
    end
  end

  // Storage arrays
  always_ff @(posedge clk) begin
    if (req_fire_o) begin
      tag_pc_q[alloc_ptr_q]   <= ibus_req_o.addr;
      tag_priv_q[alloc_ptr_q] <= priv_lvl_i;
    end
    if (fill)
      data_q[fill_ptr_q] <= ibus_rsp_i;
  end

  ////////////////////////////////////////////////////////////
  // Head of the queue
  ////////////////////////////////////////////////////////////

  assign buf_valid_o    = stored_cnt_q != '0;
  assign buf_o.instr    = data_q[rd_ptr_q].rdata;
  assign buf_o.pc       = tag_pc_q[rd_ptr_q];
  assign buf_o.priv_lvl = tag_priv_q[rd_ptr_q];
  assign buf_o.dummy    = 1'b0;
  assign buf_o.bus_err  = data_q[rd_ptr_q].err;

endmodule

/* logic/dummy_inserter.sv */
// Dummy inserter: places dummy instructions at LFSR-chosen points in the IF/ID stream
module dummy_inserter
  import fetch_pkg::*;
#(
  // Must be at least 1
  parameter logic [3:0] DUMMY_MAX_GAP = 4'd7
) (
  input  logic   clk,
  input  logic   rst_n,
  input  if_id_t buf_i,
  input  logic   buf_valid_i,
  output logic   buf_ready_o,
  input  logic   halt_i,
  input  logic   kill_i,
  input  logic   dummy_en_i,
  output if_id_t if_id_o,
  output logic   if_valid_o,
  input  logic   id_ready_i
);

  logic [15:0] lfsr_q;
  logic        lfsr_fb;
  // Real instructions still to pass before the next dummy
  logic [3:0]  gap_q;
  logic [3:0]  gap_reload;
  // Last cycle offered a word that ID did not take
  logic        hold_q;
  logic        hold_dummy_q;
  logic        insert;
  logic        xfer;

  ////////////////////////////////////////////////////////////
  // Gap selection
  ////////////////////////////////////////////////////////////

  // Taps 16, 14, 13, 11, maximal length
  assign lfsr_fb    = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
  // Range 1 to DUMMY_MAX_GAP, never zero so dummies cannot follow each other
  assign gap_reload = (lfsr_q[3:0] % DUMMY_MAX_GAP) + 4'd1;

  // An offer that is waiting keeps its kind until ID takes it
  assign insert = hold_q ? hold_dummy_q : (dummy_en_i && (gap_q == '0));

  ////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////

  // A dummy needs a real word waiting, it borrows its PC
  assign if_valid_o  = buf_valid_i && !halt_i && !kill_i;
  assign xfer        = if_valid_o && id_ready_i;
  // Pop only on a real transfer, kill drains the buffer
  assign buf_ready_o = kill_i || (xfer && !insert);

  always_comb begin
    if_id_o = buf_i;
    if (insert) begin
      if_id_o.instr   = DUMMY_INSTR;
      if_id_o.dummy   = 1'b1;
      if_id_o.bus_err = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lfsr_q       <= 16'hACE1;
      gap_q        <= DUMMY_MAX_GAP;
      hold_q       <= 1'b0;
      hold_dummy_q <= 1'b0;
    end else begin
      // Free running
      lfsr_q       <= {lfsr_q[14:0], lfsr_fb};
      hold_q       <= if_valid_o && !id_ready_i;
      hold_dummy_q <= insert;
      if (xfer) begin
        if (insert)
          gap_q <= gap_reload;
        else if (gap_q != '0)
          gap_q <= gap_q - 4'd1;
      end
    end
  end

endmodule

/* logic/if_stage.sv */
// Instruction fetch stage top: controller, prefetch buffer and dummy inserter in one block
module if_stage
  import fetch_pkg::*;
  import ibus_pkg::*;
#(
  parameter logic [31:0] BOOT_ADDR     = 32'h0000_0080,
  parameter int unsigned FIFO_DEPTH    = 4,
  parameter logic [3:0]  DUMMY_MAX_GAP = 4'd7
) (
  input  logic        clk,
  input  logic        rst_n,
  // Controller side
  input  fetch_cmd_t  fetch_cmd_i,
  input  logic [31:0] mtvec_i,
  // Instruction bus
  output ibus_req_t   ibus_req_o,
  output logic        ibus_req_valid_o,
  input  logic        ibus_req_ready_i,
  input  ibus_rsp_t   ibus_rsp_i,
  input  logic        ibus_rsp_valid_i,
  // Decode side
  output if_id_t      if_id_o,
  output logic        if_valid_o,
  input  logic        id_ready_i
);

  ////////////////////////////////////////////////////////////
  // Internal wiring
  ////////////////////////////////////////////////////////////

  logic [31:0] fetch_addr;
  logic        fetch_en;
  logic        flush;
  priv_lvl_e   priv_lvl;
  logic        req_fire;
  logic        outstanding_zero;
  if_id_t      buf_data;
  logic        buf_valid;
  logic        buf_ready;
  logic        halt;
  logic        kill;
  logic        dummy_en;

  fetch_ctrl #(
    .BOOT_ADDR (BOOT_ADDR)
  ) fetch_ctrl_i (
    .clk                (clk),
    .rst_n              (rst_n),
    .fetch_cmd_i        (fetch_cmd_i),
    .mtvec_i            (mtvec_i),
    .req_fire_i         (req_fire),
    .outstanding_zero_i (outstanding_zero),
    .fetch_addr_o       (fetch_addr),
    .fetch_en_o         (fetch_en),
    .flush_o            (flush),
    .priv_lvl_o         (priv_lvl),
    .halt_o             (halt),
    .kill_o             (kill),
    .dummy_en_o         (dummy_en)
  );

  prefetch_buffer #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) prefetch_buffer_i (
    .clk                (clk),
    .rst_n              (rst_n),
    .fetch_addr_i       (fetch_addr),
    .fetch_en_i         (fetch_en),
    .flush_i            (flush),
    .priv_lvl_i         (priv_lvl),
    .req_fire_o         (req_fire),
    .outstanding_zero_o (outstanding_zero),
    .ibus_req_o         (ibus_req_o),
    .ibus_req_valid_o   (ibus_req_valid_o),
    .ibus_req_ready_i   (ibus_req_ready_i),
    .ibus_rsp_i         (ibus_rsp_i),
    .ibus_rsp_valid_i   (ibus_rsp_valid_i),
    .buf_o              (buf_data),
    .buf_valid_o        (buf_valid),
    .buf_ready_i        (buf_ready)
  );

  // Only place where halt and kill touch if_valid_o
  dummy_inserter #(
    .DUMMY_MAX_GAP (DUMMY_MAX_GAP)
  ) dummy_inserter_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .buf_i       (buf_data),
    .buf_valid_i (buf_valid),
    .buf_ready_o (buf_ready),
    .halt_i      (halt),
    .kill_i      (kill),
    .dummy_en_i  (dummy_en),
    .if_id_o     (if_id_o),
    .if_valid_o  (if_valid_o),
    .id_ready_i  (id_ready_i)
  );

endmodule

/* verification/if_stage_checker.sv */
// Passive checker on the fetch stage ports that counts invariant violations for the final report
module if_stage_checker
  import fetch_pkg::*;
  import ibus_pkg::*;
#(
  parameter logic [31:0] BOOT_ADDR     = 32'h0000_0080,
  parameter int unsigned FIFO_DEPTH    = 4,
  parameter logic [3:0]  DUMMY_MAX_GAP = 4'd7
) (
  input  logic        clk,
  input  logic        rst_n,
  input  fetch_cmd_t  fetch_cmd_i,
  input  ibus_req_t   ibus_req_i,
  input  logic        ibus_req_valid_i,
  input  logic        ibus_req_ready_i,
  input  logic        ibus_rsp_valid_i,
  input  if_id_t      if_id_i,
  input  logic        if_valid_i,
  input  logic        id_ready_i,
  output int unsigned error_count_o
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned errors;
  int unsigned outstanding;
  // Real transfers in a row while dummies are enabled
  int unsigned real_run;
  logic        boot_seen;
  logic        held_q;
  logic        last_dummy;
  if_id_t      held_data;
  // PCs requested since the last kill in request order
  logic [31:0] live_pc[$];

  assign error_count_o = errors;

  task automatic note_violation(input string what);
    $display("Checker at %0t ns: %s", $time, what);
    errors++;
  endtask

  task automatic show_mismatch(input string name, input logic [67:0] got, input logic [67:0] exp);
    $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
    errors++;
  endtask

  ////////////////////////////////////////////////////////////
  // Sampled mid-cycle when inputs have settled since the rising edge
  ////////////////////////////////////////////////////////////

  always @(negedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding = 0;
      real_run    = 0;
      boot_seen   = 1'b0;
      held_q      = 1'b0;
      last_dummy  = 1'b0;
      held_data   = '0;
      live_pc.delete();
    end else begin
      // Bus side takes the response first so a same-cycle request is not counted as answered
      if (ibus_rsp_valid_i)
        outstanding--;
      if (ibus_req_valid_i && ibus_req_ready_i) begin
        if (ibus_req_i.addr[1:0] != 2'b00)
          note_violation("bus request address is not word aligned");
        if (!boot_seen && ibus_req_i.addr != BOOT_ADDR)
          show_mismatch("ibus_req_o.addr", 68'(ibus_req_i.addr), 68'(BOOT_ADDR));
        boot_seen = 1'b1;
        live_pc.push_back(ibus_req_i.addr);
        outstanding++;
      end
      if (outstanding > FIFO_DEPTH)
        note_violation("more bus requests outstanding than the buffer depth");

      // Halt and kill gating
      if (fetch_cmd_i.kill && if_valid_i)
        note_violation("if_valid_o high in a kill cycle");
      if (fetch_cmd_i.halt && !fetch_cmd_i.kill && if_valid_i)
        note_violation("if_valid_o high while halted");

      // Payload held while decode stalls
      if (held_q && if_valid_i && if_id_i != held_data)
        show_mismatch("if_id_o", if_id_i, held_data);

      ////////////////////////////////////////////////////////////
      // Transfers to decode
      ////////////////////////////////////////////////////////////

      if (if_valid_i && id_ready_i) begin
        // Only words requested after the last kill may arrive
        if (live_pc.size() == 0)
          note_violation("transfer with no request issued since the last kill");
        else if (if_id_i.pc != live_pc[0])
          show_mismatch("if_id_o.pc", 68'(if_id_i.pc), 68'(live_pc[0]));
        if (if_id_i.dummy) begin
          if (last_dummy)
            note_violation("two dummy instructions transferred back to back");
          // A held dummy offer was decided in an earlier cycle
          if (!held_q && !fetch_cmd_i.dummy_en)
            note_violation("dummy instruction inserted while dummy_en is low");
          real_run = 0;
        end else begin
          if (live_pc.size() != 0)
            void'(live_pc.pop_front());
          if (fetch_cmd_i.dummy_en)
            real_run++;
          if (real_run > DUMMY_MAX_GAP)
            note_violation("too many real instructions without a dummy");
        end
        last_dummy = if_id_i.dummy;
      end

      if (!fetch_cmd_i.dummy_en)
        real_run = 0;
      if (fetch_cmd_i.kill)
        live_pc.delete();
      held_q    = if_valid_i && !id_ready_i;
      held_data = if_id_i;
    end
  end

endmodule

/* verification/tb_if_stage.sv */
// Testbench top for the fetch stage that drives random controller and decode traffic against a bus model
module tb_if_stage
  import fetch_pkg::*;
  import ibus_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] BOOT_ADDR      = 32'h0000_0080;
  // Two entries so the 1 to 3 cycle bus latency can press against the request limit
  localparam int unsigned FIFO_DEPTH     = 2;
  localparam logic [3:0]  DUMMY_MAX_GAP  = 4'd5;
  localparam int unsigned NUM_CYCLES     = 2000;
  localparam int unsigned TIMEOUT_CYCLES = 2 * NUM_CYCLES;
  localparam logic [31:0] MEM_KEY        = 32'hA5A5_0000;
  // Words at and above this address fault
  localparam logic [31:0] ERR_BASE       = 32'hF000_0000;
  // add x0, x0, x0
  localparam logic [31:0] ADD_X0         = 32'h0000_0033;

  logic        clk;
  logic        rst_n;
  fetch_cmd_t  fetch_cmd;
  logic [31:0] mtvec;
  ibus_req_t   ibus_req;
  logic        ibus_req_valid;
  logic        ibus_req_ready;
  ibus_rsp_t   ibus_rsp;
  logic        ibus_rsp_valid;
  if_id_t      if_id;
  logic        if_valid;
  logic        id_ready;

  logic [31:0] rng;
  int unsigned cycle = 0;
  int unsigned model_errors = 0;
  int unsigned checker_errors;
  int unsigned real_count = 0;
  int unsigned dummy_count = 0;
  // Reference model state
  logic [31:0] exp_pc;
  priv_lvl_e   exp_priv;
  // Bus model queues of accepted addresses and the cycle each answer is due
  logic [31:0] pend_addr[$];
  int unsigned pend_due[$];

  if_stage #(
    .BOOT_ADDR     (BOOT_ADDR),
    .FIFO_DEPTH    (FIFO_DEPTH),
    .DUMMY_MAX_GAP (DUMMY_MAX_GAP)
  ) dut_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .fetch_cmd_i      (fetch_cmd),
    .mtvec_i          (mtvec),
    .ibus_req_o       (ibus_req),
    .ibus_req_valid_o (ibus_req_valid),
    .ibus_req_ready_i (ibus_req_ready),
    .ibus_rsp_i       (ibus_rsp),
    .ibus_rsp_valid_i (ibus_rsp_valid),
    .if_id_o          (if_id),
    .if_valid_o       (if_valid),
    .id_ready_i       (id_ready)
  );

  if_stage_checker #(
    .BOOT_ADDR     (BOOT_ADDR),
    .FIFO_DEPTH    (FIFO_DEPTH),
    .DUMMY_MAX_GAP (DUMMY_MAX_GAP)
  ) monitor_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .fetch_cmd_i      (fetch_cmd),
    .ibus_req_i       (ibus_req),
    .ibus_req_valid_i (ibus_req_valid),
    .ibus_req_ready_i (ibus_req_ready),
    .ibus_rsp_valid_i (ibus_rsp_valid),
    .if_id_i          (if_id),
    .if_valid_i       (if_valid),
    .id_ready_i       (id_ready),
    .error_count_o    (checker_errors)
  );

  ////////////////////////////////////////////////////////////
  // Clock and cycle limit
  ////////////////////////////////////////////////////////////

  initial clk = 1'b0;
  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle = cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
    model_errors++;
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus applied just after the rising edge
  ////////////////////////////////////////////////////////////

  task automatic drive_cycle(input bit allow_cmd);
    logic [31:0] r;
    logic [31:0] r2;
    rng = xorshift32(rng);
    r   = rng;
    rng = xorshift32(rng);
    r2  = rng;
    fetch_cmd.halt   = 1'b0;
    fetch_cmd.kill   = 1'b0;
    fetch_cmd.pc_set = 1'b0;
    if (allow_cmd) begin
      if (r[4:0] == 5'd0) begin
        // Redirect where one jump in four lands in the fault region
        fetch_cmd.kill     = 1'b1;
        fetch_cmd.pc_set   = 1'b1;
        fetch_cmd.new_priv = r2[8] ? PRIV_M : PRIV_U;
        if (r2[3:2] == 2'd0)
          fetch_cmd.jump_target = {4'hF, r2[31:6], 2'b00};
        else
          fetch_cmd.jump_target = {16'h0000, r2[31:18], 2'b00};
        case (r2[1:0])
          2'd0:    fetch_cmd.pc_mux = PC_BOOT;
          2'd1:    fetch_cmd.pc_mux = PC_TRAP;
          default: fetch_cmd.pc_mux = PC_JUMP;
        endcase
        // Model restarts the stream at the new target
        case (fetch_cmd.pc_mux)
          PC_JUMP: exp_pc = fetch_cmd.jump_target;
          PC_TRAP: exp_pc = mtvec;
          default: exp_pc = BOOT_ADDR;
        endcase
        exp_priv = fetch_cmd.new_priv;
      end else if (r[12:5] == 8'd0) begin
        // Kill alone parks fetching until the next redirect
        fetch_cmd.kill = 1'b1;
      end else if (r[15:13] == 3'd0) begin
        fetch_cmd.halt = 1'b1;
      end
      if (r[21:16] == 6'd0)
        fetch_cmd.dummy_en = !fetch_cmd.dummy_en;
    end
    id_ready       = r[23:22] != 2'd0;
    ibus_req_ready = r[25:24] != 2'd0;
    // Oldest request answered once its latency is up
    ibus_rsp_valid = 1'b0;
    if (pend_addr.size() != 0 && pend_due[0] <= cycle) begin
      ibus_rsp_valid = 1'b1;
      ibus_rsp.rdata = pend_addr[0] ^ MEM_KEY;
      ibus_rsp.err   = pend_addr[0] >= ERR_BASE;
      void'(pend_addr.pop_front());
      void'(pend_due.pop_front());
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Response sampling at the falling edge
  ////////////////////////////////////////////////////////////

  task automatic sample_cycle();
    if (ibus_req_valid && ibus_req_ready) begin
      rng = xorshift32(rng);
      pend_addr.push_back(ibus_req.addr);
      // Latency of 1 to 3 cycles after acceptance
      pend_due.push_back(cycle + 1 + rng % 3);
    end
    if (if_valid && id_ready) begin
      if (if_id.priv_lvl != exp_priv)
        report_mismatch("if_id_o.priv_lvl", 32'(if_id.priv_lvl), 32'(exp_priv));
      if (if_id.pc != exp_pc)
        report_mismatch("if_id_o.pc", if_id.pc, exp_pc);
      if (if_id.dummy) begin
        dummy_count++;
        if (if_id.instr != ADD_X0)
          report_mismatch("if_id_o.instr", if_id.instr, ADD_X0);
      end else begin
        real_count++;
        if (if_id.instr != (exp_pc ^ MEM_KEY))
          report_mismatch("if_id_o.instr", if_id.instr, exp_pc ^ MEM_KEY);
        if (if_id.bus_err != (exp_pc >= ERR_BASE))
          report_mismatch("if_id_o.bus_err", 32'(if_id.bus_err), 32'(exp_pc >= ERR_BASE));
        exp_pc = exp_pc + 32'd4;
      end
    end
  endtask

  initial begin
    rng                = 32'h51f3;
    fetch_cmd          = '0;
    fetch_cmd.dummy_en = 1'b1;
    mtvec              = 32'h0000_2000;
    ibus_req_ready     = 1'b0;
    ibus_rsp           = '0;
    ibus_rsp_valid     = 1'b0;
    id_ready           = 1'b0;
    exp_pc             = BOOT_ADDR;
    exp_priv           = PRIV_M;
    rst_n              = 1'b0;
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
    // Quiet controller for the first cycles so the boot fetch goes out
    for (int i = 0; i < NUM_CYCLES; i++) begin
      @(posedge clk);
      #1 drive_cycle(i >= 10);
      @(negedge clk);
      sample_cycle();
    end
    if (real_count < 200) begin
      $display("Too few instructions reached decode: %0d", real_count);
      model_errors++;
    end
    if (dummy_count == 0) begin
      $display("No dummy instruction reached decode");
      model_errors++;
    end
    $display("Errors: reference model %0d, checker %0d", model_errors, checker_errors);
    if (model_errors + checker_errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

/* if_stage.f */
logic/fetch_pkg.sv
logic/ibus_pkg.sv
logic/fetch_ctrl.sv
logic/prefetch_buffer.sv
logic/dummy_inserter.sv
logic/if_stage.sv
verification/if_stage_checker.sv
verification/tb_if_stage.sv

/* Makefile */
TOP := tb_if_stage

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
		--top-module $(TOP) -f if_stage.f

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
